//--- design/pma_config.svh
// PMA lookup unit configuration
// Table size and address geometry shared by the package and the RTL

`ifndef PMA_CONFIG_SVH
`define PMA_CONFIG_SVH

// Number of entries in the region table
`define PMA_NUM_REGIONS 4

// Byte address width of a request
`define PMA_ADDR_W 32

// Address bits below this one are ignored by every bounds check
`define PMA_WORD_LSB 2

// Width of a region index
`define PMA_REGION_W 2

`endif

//--- design/pma_pkg.sv
// PMA lookup types and constants
// Region attribute layout, the fallback attributes and the fixed region table

`default_nettype none

package pma_pkg;

  `include "pma_config.svh"

  // One region with word bounds [low, high) and its attribute bits
  typedef struct packed {
    logic [`PMA_ADDR_W-`PMA_WORD_LSB-1:0] word_addr_low;
    logic [`PMA_ADDR_W-`PMA_WORD_LSB-1:0] word_addr_high;
    logic                                 main;
    logic                                 bufferable;
    logic                                 cacheable;
    logic                                 atomic;
  } pma_cfg_t;

  typedef logic [`PMA_REGION_W-1:0] pma_region_t;

  // Used when no region contains the address and allows nothing
  localparam pma_cfg_t PMA_R_DEFAULT = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0,
    atomic:         1'b0
  };

  ////////////////////////////////////////////////////////////////////////////
  // Region table with bounds as word addresses (byte address >> 2)
  ////////////////////////////////////////////////////////////////////////////

  localparam pma_cfg_t PMA_REGION_TABLE [`PMA_NUM_REGIONS] = '{
    // Main memory from 0x0000_0000 to 0x0001_0000
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1},
    // Peripheral window from 0x1000_0000 to 0x1000_1000
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // Main memory with all features from 0x2000_0000 to 0x3000_0000
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0C00_0000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1},
    // From 0x0000_8000 to 0x2000_0000, overlapping region 0 and touching region 2
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0800_0000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0}
  };

endpackage : pma_pkg

`default_nettype wire

//--- design/pma_req_if.sv
// PMA request bundle
// Carries one registered lookup request from the input stage to the
// region comparators and the attribute selector

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

interface pma_req_if;

  logic                   valid;
  logic [`PMA_ADDR_W-1:0] addr;
  logic                   instr_fetch;
  logic                   misaligned;
  logic                   atomic;
  logic                   load;

  // Input register drives the whole request
  modport stage_mp (
    output valid, addr, instr_fetch, misaligned, atomic, load
  );

  // Comparators only look at the address
  modport match_mp (input addr);

  modport select_mp (
    input valid, addr, instr_fetch, misaligned, atomic, load
  );

endinterface : pma_req_if

`default_nettype wire

//--- design/pma_req_stage.sv
// PMA request input stage
// Registers the incoming request so the comparator tree sees only flop outputs

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

module pma_req_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  logic [`PMA_ADDR_W-1:0] addr_i,
  input  logic                   instr_fetch_i,
  input  logic                   misaligned_i,
  input  logic                   atomic_i,
  input  logic                   load_i,
  pma_req_if.stage_mp            req
);

  // Valid bit follows the strobe every cycle
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= req_valid_i;
    end
  end

  // Payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      req.addr        <= addr_i;
      req.instr_fetch <= instr_fetch_i;
      req.misaligned  <= misaligned_i;
      req.atomic      <= atomic_i;
      req.load        <= load_i;
    end
  end

endmodule : pma_req_stage

`default_nettype wire

//--- design/pma_region_match.sv
// PMA region comparator
// Checks the registered request address against one table entry's bounds

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

module pma_region_match import pma_pkg::*; #(
  parameter int region_idx = 0
) (
  pma_req_if.match_mp req,
  output logic        hit_o
);

  localparam pma_cfg_t REGION_CFG = PMA_REGION_TABLE[region_idx];

  logic [`PMA_ADDR_W-`PMA_WORD_LSB-1:0] word_addr;

  // Byte offset within the word plays no part in the match
  assign word_addr = req.addr[`PMA_ADDR_W-1:`PMA_WORD_LSB];

  // Lower bound inclusive, upper bound exclusive
  assign hit_o = (word_addr >= REGION_CFG.word_addr_low) &&
                 (word_addr <  REGION_CFG.word_addr_high);

endmodule : pma_region_match

`default_nettype wire

//--- design/pma_attr_select.sv
// PMA attribute selector
// Picks the lowest-numbered hit region, derives the access flags from its
// attributes and registers the result

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

module pma_attr_select import pma_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  pma_req_if.select_mp                req,
  input  logic [`PMA_NUM_REGIONS-1:0] hit_i,
  output logic                        resp_valid_o,
  output pma_region_t                 region_o,
  output logic                        match_o,
  output logic                        err_o,
  output logic                        bufferable_o,
  output logic                        cacheable_o
);

  pma_cfg_t    sel_cfg;
  pma_region_t sel_region;
  logic        sel_match;
  logic        err_d;
  logic        bufferable_d;
  logic        cacheable_d;

  ////////////////////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////////////////////

  // Walk from the top down so the lowest set bit is the last to win
  always_comb begin
    sel_cfg    = PMA_R_DEFAULT;
    sel_region = '0;
    sel_match  = 1'b0;
    for (int i = `PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        sel_cfg    = PMA_REGION_TABLE[i];
        sel_region = pma_region_t'(i);
        sel_match  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access checks
  ////////////////////////////////////////////////////////////////////////////

  // Fetch and misaligned accesses need main memory and atomics need support
  assign err_d = (req.instr_fetch && !sel_cfg.main) ||
                 (req.misaligned  && !sel_cfg.main) ||
                 (req.atomic      && !sel_cfg.atomic);

  // Only plain stores may be buffered
  assign bufferable_d = sel_cfg.bufferable &&
                        !req.load && !req.atomic && !req.instr_fetch;

  assign cacheable_d = sel_cfg.cacheable;

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
      region_o     <= '0;
      match_o      <= 1'b0;
      err_o        <= 1'b0;
      bufferable_o <= 1'b0;
      cacheable_o  <= 1'b0;
    end else begin
      resp_valid_o <= req.valid;
      if (req.valid) begin
        region_o     <= sel_region;
        match_o      <= sel_match;
        err_o        <= err_d;
        bufferable_o <= bufferable_d;
        cacheable_o  <= cacheable_d;
      end else begin
        // Idle cycles show a clean all-zero result
        region_o     <= '0;
        match_o      <= 1'b0;
        err_o        <= 1'b0;
        bufferable_o <= 1'b0;
        cacheable_o  <= 1'b0;
      end
    end
  end

endmodule : pma_attr_select

`default_nettype wire

//--- design/pma_unit.sv
// PMA lookup unit
// Two-stage pipeline of a request register and per-region comparators
// feeding a priority selector with a registered result

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

module pma_unit import pma_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  logic [`PMA_ADDR_W-1:0] addr_i,
  input  logic                   instr_fetch_i,
  input  logic                   misaligned_i,
  input  logic                   atomic_i,
  input  logic                   load_i,
  output logic                   resp_valid_o,
  output pma_region_t            region_o,
  output logic                   match_o,
  output logic                   err_o,
  output logic                   bufferable_o,
  output logic                   cacheable_o
);

  pma_req_if req_if ();

  // One bit per table entry
  logic [`PMA_NUM_REGIONS-1:0] hit;

  pma_req_stage pma_req_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .addr_i        (addr_i),
    .instr_fetch_i (instr_fetch_i),
    .misaligned_i  (misaligned_i),
    .atomic_i      (atomic_i),
    .load_i        (load_i),
    .req           (req_if.stage_mp)
  );

  for (genvar i = 0; i < `PMA_NUM_REGIONS; i++) begin : g_region
    pma_region_match #(
      .region_idx (i)
    ) pma_region_match_inst (
      .req   (req_if.match_mp),
      .hit_o (hit[i])
    );
  end

  pma_attr_select pma_attr_select_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req_if.select_mp),
    .hit_i        (hit),
    .resp_valid_o (resp_valid_o),
    .region_o     (region_o),
    .match_o      (match_o),
    .err_o        (err_o),
    .bufferable_o (bufferable_o),
    .cacheable_o  (cacheable_o)
  );

endmodule : pma_unit

`default_nettype wire

//--- tb/pma_tb_ref.svh
// PMA lookup reference model
// Computes the expected lookup result of one request by walking the region
// table from index 0

`ifndef PMA_TB_REF_SVH
`define PMA_TB_REF_SVH

typedef struct packed {
  logic        match;
  pma_region_t region;
  logic        err;
  logic        bufferable;
  logic        cacheable;
} lookup_result_t;

function automatic lookup_result_t lookup_expected(
  input logic [`PMA_ADDR_W-1:0] addr,
  input logic                   fetch,
  input logic                   misaligned,
  input logic                   atomic,
  input logic                   load
);
  lookup_result_t                       res;
  pma_cfg_t                             attr;
  logic [`PMA_ADDR_W-`PMA_WORD_LSB-1:0] word;
  logic                                 found;
  res   = '0;
  attr  = PMA_R_DEFAULT;
  word  = addr[`PMA_ADDR_W-1:`PMA_WORD_LSB];
  found = 1'b0;
  // First region containing the word wins
  for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
    if (!found && word >= PMA_REGION_TABLE[i].word_addr_low &&
        word < PMA_REGION_TABLE[i].word_addr_high) begin
      found      = 1'b1;
      attr       = PMA_REGION_TABLE[i];
      res.region = pma_region_t'(i);
    end
  end
  res.match      = found;
  res.err        = ((fetch || misaligned) && !attr.main) || (atomic && !attr.atomic);
  res.bufferable = attr.bufferable && !(load || atomic || fetch);
  res.cacheable  = attr.cacheable;
  return res;
endfunction

`endif

//--- tb/pma_unit_tb.sv
// PMA lookup unit testbench
// Drives directed and random requests and checks every result against
// the reference model through a queue of expected values

`timescale 1ns/1ps
`default_nettype none

`include "pma_config.svh"

module pma_unit_tb import pma_pkg::*; ();

  `include "pma_tb_ref.svh"

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid_i;
  logic [`PMA_ADDR_W-1:0] addr_i;
  logic                   instr_fetch_i;
  logic                   misaligned_i;
  logic                   atomic_i;
  logic                   load_i;
  logic                   resp_valid_o;
  pma_region_t            region_o;
  logic                   match_o;
  logic                   err_o;
  logic                   bufferable_o;
  logic                   cacheable_o;

  lookup_result_t exp_q[$];
  string          test_name;
  int             seed = 4896;
  int             errors = 0;
  int             checks = 0;
  int             tests = 0;
  int             test_err_start = 0;

  pma_unit pma_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .addr_i        (addr_i),
    .instr_fetch_i (instr_fetch_i),
    .misaligned_i  (misaligned_i),
    .atomic_i      (atomic_i),
    .load_i        (load_i),
    .resp_valid_o  (resp_valid_o),
    .region_o      (region_o),
    .match_o       (match_o),
    .err_o         (err_o),
    .bufferable_o  (bufferable_o),
    .cacheable_o   (cacheable_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
    end
  endtask

  task automatic check_idle_outputs();
    check_value("resp_valid", 0, resp_valid_o);
    check_value("match", 0, match_o);
    check_value("err", 0, err_o);
    check_value("bufferable", 0, bufferable_o);
    check_value("cacheable", 0, cacheable_o);
    check_value("region", 0, region_o);
  endtask

  // Drive one request on the falling edge and queue its expected result
  task automatic send_request(input logic [31:0] addr, input logic [3:0] flags);
    @(negedge clk);
    req_valid_i   = 1'b1;
    addr_i        = addr;
    {instr_fetch_i, misaligned_i, atomic_i, load_i} = flags;
    exp_q.push_back(lookup_expected(addr, flags[3], flags[2], flags[1], flags[0]));
  endtask

  task automatic go_idle();
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  // Wait a bounded time for all outstanding results
  task automatic end_test();
    int cnt;
    go_idle();
    for (cnt = 0; cnt < 20 && exp_q.size() != 0; cnt++) @(negedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout in %s: %0d results never arrived", test_name, exp_q.size());
      exp_q.delete();
    end
    tests++;
    $display("Test %-10s finished with %0d errors", test_name, errors - test_err_start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result checker
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare_proc
    lookup_result_t want;
    forever begin
      @(negedge clk);
      if (rst_n && resp_valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result appeared with no request outstanding in %s", test_name);
        end else begin
          want = exp_q.pop_front();
          check_value("match", want.match, match_o);
          check_value("region", want.region, region_o);
          check_value("err", want.err, err_o);
          check_value("bufferable", want.bufferable, bufferable_o);
          check_value("cacheable", want.cacheable, cacheable_o);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int          lat;
    int          r;
    int          off;
    logic [31:0] a;
    pma_cfg_t    cfg;
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    addr_i = '0;
    instr_fetch_i = 1'b0;
    misaligned_i = 1'b0;
    atomic_i = 1'b0;
    load_i = 1'b0;

    begin_test("reset");
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_idle_outputs();
    end
    end_test();

    begin_test("latency");
    send_request(32'h0000_0040, 4'b0000);
    @(negedge clk);
    req_valid_i = 1'b0;
    lat = 1;
    while (!resp_valid_o && lat < 10) begin
      @(negedge clk);
      lat++;
    end
    if (!resp_valid_o) begin
      errors++;
      $display("Timeout in %s: no result after a single request", test_name);
    end else begin
      check_value("latency", 2, lat);
    end
    // Back-to-back burst with distinct entries so ordering shows up
    for (int k = 0; k < 8; k++) begin
      send_request({PMA_REGION_TABLE[k % `PMA_NUM_REGIONS].word_addr_low, 2'b00} + k * 4,
                   4'(k));
      // Results trail their requests by two cycles without gaps
      check_value("burst_valid", (k >= 2), resp_valid_o);
    end
    go_idle();
    check_value("burst_valid", 1, resp_valid_o);
    @(negedge clk);
    check_value("burst_valid", 1, resp_valid_o);
    @(negedge clk);
    check_value("burst_valid", 0, resp_valid_o);
    end_test();

    begin_test("priority");
    send_request(32'h0000_9000, 4'b0000);
    send_request(32'h0001_0000, 4'b0000);
    send_request(32'h2000_0000, 4'b0000);
    send_request(32'h1FFF_FFFC, 4'b0000);
    end_test();

    begin_test("error");
    send_request(32'h4000_0000, 4'b1000);
    send_request(32'h4000_0002, 4'b0100);
    send_request(32'h1000_0010, 4'b1000);
    send_request(32'h0010_0000, 4'b0010);
    send_request(32'h0000_0100, 4'b0010);
    end_test();

    begin_test("attributes");
    send_request(32'h2000_1000, 4'b0000);
    send_request(32'h2000_1000, 4'b0001);
    send_request(32'h2000_1000, 4'b0010);
    send_request(32'h1000_0020, 4'b0000);
    send_request(32'h1000_0020, 4'b0001);
    end_test();

    begin_test("random");
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      cfg = PMA_REGION_TABLE[$unsigned(r) % `PMA_NUM_REGIONS];
      if (r[3:2] == 2'b00) begin
        a = $random(seed);
      end else begin
        // Land a few words either side of a region bound
        off = $random(seed) % 8;
        a = {(r[4] ? cfg.word_addr_high : cfg.word_addr_low), 2'b00};
        a = a + 32'(off * 4) + 32'(r[11:10]);
      end
      send_request(a, r[15:12]);
    end
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : pma_unit_tb

`default_nettype wire

//--- project.f
+incdir+design
+incdir+tb
design/pma_pkg.sv
design/pma_req_if.sv
design/pma_req_stage.sv
design/pma_region_match.sv
design/pma_attr_select.sv
design/pma_unit.sv
tb/pma_unit_tb.sv
